// ==== common/uart_bridge_pkg.sv ====
package uart_bridge_pkg;

  // Command word layout.
  localparam int CMD_WIDTH  = 16;
  localparam int DATA_WIDTH = 8;
  localparam int ADDR_WIDTH = 7;
  localparam int RW_BIT     = 15; // 1 is a write.

  // Serial timing.
  localparam int CLKS_PER_BIT = 8; // 434 on a 50 MHz board at 115200 baud.
  localparam int FRAME_BITS   = 11;
  localparam int GAP_CYCLES   = 100;
  localparam int RESP_TIMEOUT = 400;

  localparam int BIT_CNT_WIDTH  = $clog2(FRAME_BITS);
  localparam int BAUD_CNT_WIDTH = $clog2(CLKS_PER_BIT);
  localparam int GAP_CNT_WIDTH  = $clog2(GAP_CYCLES);
  localparam int TMO_CNT_WIDTH  = $clog2(RESP_TIMEOUT);

  // Sequencer states.
  localparam int STATE_WIDTH = 3;
  localparam logic [STATE_WIDTH-1:0] ST_IDLE    = 3'd0;
  localparam logic [STATE_WIDTH-1:0] ST_SEND_HI = 3'd1;
  localparam logic [STATE_WIDTH-1:0] ST_HI_WAIT = 3'd2;
  localparam logic [STATE_WIDTH-1:0] ST_GAP     = 3'd3;
  localparam logic [STATE_WIDTH-1:0] ST_SEND_LO = 3'd4;
  localparam logic [STATE_WIDTH-1:0] ST_LO_WAIT = 3'd5;
  localparam logic [STATE_WIDTH-1:0] ST_AWAIT   = 3'd6;
  localparam logic [STATE_WIDTH-1:0] ST_REPORT  = 3'd7;

endpackage

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [uart_bridge_pkg::DATA_WIDTH-1:0] tx_byte,
  input  logic                                  tx_vld,
  output logic                                  tx_rdy,
  output logic                                  tx
);
  import uart_bridge_pkg::*;

  logic                      busy;
  logic [BAUD_CNT_WIDTH-1:0] baud_cnt;
  logic [BIT_CNT_WIDTH-1:0]  bit_cnt;
  logic [FRAME_BITS-2:0]     frame_q; // Stop, parity and data, sent from bit 0 up.
  logic                      start;
  logic                      bit_end;

  assign tx_rdy  = ~busy;
  assign start   = tx_vld & tx_rdy;
  assign bit_end = busy && (baud_cnt == BAUD_CNT_WIDTH'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;
    end
    else if (start)
    begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b0; // Start bit.
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_cnt == BIT_CNT_WIDTH'(FRAME_BITS - 1))
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        bit_cnt <= bit_cnt + 1'b1;
        tx      <= frame_q[0];
      end
    end
    else if (busy)
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Odd parity makes the nine bits hold an odd number of ones.
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      frame_q <= {1'b1, ~^tx_byte, tx_byte};
    end
    else if (bit_end)
    begin
      frame_q <= {1'b1, frame_q[FRAME_BITS-2:1]};
    end
  end

endmodule

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  rx,
  output logic [uart_bridge_pkg::DATA_WIDTH-1:0] rx_byte,
  output logic                                  rx_vld,
  output logic                                  rx_err
);
  import uart_bridge_pkg::*;

  logic                      rx_meta;
  logic                      rx_sync;
  logic                      rx_prev;
  logic                      busy;
  logic [BAUD_CNT_WIDTH-1:0] baud_cnt;
  logic [BIT_CNT_WIDTH-1:0]  bit_cnt;
  logic [DATA_WIDTH-1:0]     shift_q;
  logic                      par_q;
  logic                      fall;
  logic                      bit_end;
  logic                      sample;

  assign fall    = rx_prev & ~rx_sync;
  assign bit_end = baud_cnt == BAUD_CNT_WIDTH'(CLKS_PER_BIT - 1);
  assign sample  = busy && (baud_cnt == BAUD_CNT_WIDTH'(CLKS_PER_BIT / 2 - 1));

  // Line idles high.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_vld   <= 1'b0;
    end
    else
    begin
      rx_vld <= 1'b0;
      if (!busy)
      begin
        if (fall)
        begin
          busy     <= 1'b1;
          baud_cnt <= BAUD_CNT_WIDTH'(1); // Low level already seen for one cycle.
          bit_cnt  <= '0;
        end
      end
      else
      begin
        baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
        if (bit_end)
          bit_cnt <= bit_cnt + 1'b1;
        if (sample)
        begin
          if (bit_cnt == '0 && rx_sync)
            busy <= 1'b0; // Glitch, not a start bit.
          else if (bit_cnt == BIT_CNT_WIDTH'(FRAME_BITS - 1))
          begin
            busy   <= 1'b0;
            rx_vld <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_cnt >= BIT_CNT_WIDTH'(1) && bit_cnt <= BIT_CNT_WIDTH'(DATA_WIDTH))
        shift_q <= {rx_sync, shift_q[DATA_WIDTH-1:1]}; // LSB arrives first.
      if (bit_cnt == BIT_CNT_WIDTH'(DATA_WIDTH + 1))
        par_q <= rx_sync;
      if (bit_cnt == BIT_CNT_WIDTH'(FRAME_BITS - 1))
      begin
        rx_byte <= shift_q;
        rx_err  <= ~(^{par_q, shift_q}) | ~rx_sync;
      end
    end
  end

endmodule

// ==== verilog/cmd_sequencer.sv ====
`timescale 1ns/1ps

module cmd_sequencer (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [uart_bridge_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                                  cmd_vld,
  input  logic                                  tx_rdy,
  input  logic [uart_bridge_pkg::DATA_WIDTH-1:0] rx_byte,
  input  logic                                  rx_vld,
  input  logic                                  rx_err,
  output logic                                  cmd_rdy,
  output logic [uart_bridge_pkg::DATA_WIDTH-1:0] tx_byte,
  output logic                                  tx_vld,
  output logic                                  read_vld,
  output logic [uart_bridge_pkg::DATA_WIDTH-1:0] read_data,
  output logic                                  read_err
);
  import uart_bridge_pkg::*;

  logic [STATE_WIDTH-1:0]   state;
  logic [CMD_WIDTH-1:0]     cmd_buf;
  logic [GAP_CNT_WIDTH-1:0] gap_cnt;
  logic [TMO_CNT_WIDTH-1:0] tmo_cnt;
  logic [DATA_WIDTH-1:0]    hi_byte;
  logic                     cmd_take;
  logic                     is_write;
  logic                     gap_done;
  logic                     tmo_hit;

  assign cmd_rdy  = state == ST_IDLE;
  assign cmd_take = cmd_vld & cmd_rdy;
  assign is_write = cmd_buf[RW_BIT];
  assign hi_byte  = {cmd_buf[RW_BIT], cmd_buf[RW_BIT-1 -: ADDR_WIDTH]};

  assign tx_vld   = (state == ST_SEND_HI) || (state == ST_SEND_LO);
  assign tx_byte  = (state == ST_SEND_LO) ? cmd_buf[DATA_WIDTH-1:0] : hi_byte;
  assign read_vld = state == ST_REPORT;

  // Gap state lasts GAP_CYCLES - 2 cycles.
  // The wait-state exit and the low-byte hand-off add two more.
  assign gap_done = gap_cnt == GAP_CNT_WIDTH'(GAP_CYCLES - 3);
  assign tmo_hit  = tmo_cnt == TMO_CNT_WIDTH'(RESP_TIMEOUT - 1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= ST_IDLE;
      gap_cnt <= '0;
      tmo_cnt <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (cmd_take)
            state <= ST_SEND_HI;
        end
        ST_SEND_HI:
        begin
          if (tx_rdy)
            state <= ST_HI_WAIT;
        end
        ST_HI_WAIT:
        begin
          if (tx_rdy) // Stop bit of the high byte is over.
          begin
            if (is_write)
            begin
              state   <= ST_GAP;
              gap_cnt <= '0;
            end
            else
            begin
              state   <= ST_AWAIT;
              tmo_cnt <= '0;
            end
          end
        end
        ST_GAP:
        begin
          if (gap_done)
            state <= ST_SEND_LO;
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        ST_SEND_LO:
        begin
          if (tx_rdy)
            state <= ST_LO_WAIT;
        end
        ST_LO_WAIT:
        begin
          if (tx_rdy)
            state <= ST_IDLE;
        end
        ST_AWAIT:
        begin
          if (rx_vld || tmo_hit)
            state <= ST_REPORT;
          else
            tmo_cnt <= tmo_cnt + 1'b1;
        end
        ST_REPORT:
        begin
          state <= ST_IDLE;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_take)
      cmd_buf <= cmd_in;
    if (state == ST_AWAIT)
    begin
      if (rx_vld)
      begin
        read_data <= rx_byte;
        read_err  <= rx_err;
      end
      else if (tmo_hit)
      begin
        read_data <= '0; // No answer from the device.
        read_err  <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module uart_cmd_bridge (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [uart_bridge_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                                  cmd_vld,
  input  logic                                  rx,
  output logic                                  cmd_rdy,
  output logic                                  tx,
  output logic                                  read_vld,
  output logic [uart_bridge_pkg::DATA_WIDTH-1:0] read_data,
  output logic                                  read_err
);
  import uart_bridge_pkg::*;

  logic [DATA_WIDTH-1:0] tx_byte;
  logic                  tx_vld;
  logic                  tx_rdy;
  logic [DATA_WIDTH-1:0] rx_byte;
  logic                  rx_vld;
  logic                  rx_err;

  cmd_sequencer cmd_sequencer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .tx_rdy    (tx_rdy),
    .rx_byte   (rx_byte),
    .rx_vld    (rx_vld),
    .rx_err    (rx_err),
    .cmd_rdy   (cmd_rdy),
    .tx_byte   (tx_byte),
    .tx_vld    (tx_vld),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx uart_tx_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_byte (tx_byte),
    .tx_vld  (tx_vld),
    .tx_rdy  (tx_rdy),
    .tx      (tx)
  );

  // Response path from the remote device.
  uart_rx uart_rx_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_byte (rx_byte),
    .rx_vld  (rx_vld),
    .rx_err  (rx_err)
  );

endmodule

// ==== sim/uart_device_model.sv ====
`timescale 1ns/1ps

module uart_device_model (
  input  logic clk,
  input  logic rst_n,
  input  logic tx,
  input  logic corrupt_parity,
  input  logic silent,
  output logic rx,
  output int   frame_errs,
  output int   parity_errs,
  output int   cmd_cnt,
  output int   min_gap
);
  import uart_bridge_pkg::*;

  localparam int RESP_DELAY = 20;

  logic [DATA_WIDTH-1:0] regs [2**ADDR_WIDTH];

  // Returns one byte from tx and the idle cycles seen before its start bit.
  task automatic receive_frame(output logic [DATA_WIDTH-1:0] data, output int idle);
    idle = 0;
    @(posedge clk);
    while (tx)
    begin
      idle++;
      @(posedge clk);
    end
    repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk); // Middle of the start bit.
    if (tx)
      frame_errs++;
    for (int i = 0; i < DATA_WIDTH; i++)
    begin
      repeat (CLKS_PER_BIT) @(posedge clk);
      data[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(posedge clk);
    if (tx != ~^data)
      parity_errs++;
    repeat (CLKS_PER_BIT) @(posedge clk);
    if (!tx)
      frame_errs++; // Stop bit low.
  endtask

  task automatic send_frame(input logic [DATA_WIDTH-1:0] data);
    logic [FRAME_BITS-1:0] bits;
    bits = {1'b1, (~^data) ^ corrupt_parity, data, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      @(posedge clk);
      #1 rx = bits[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  initial
  begin
    logic [DATA_WIDTH-1:0] hi;
    logic [DATA_WIDTH-1:0] lo;
    int                    idle;
    rx          = 1'b1;
    frame_errs  = 0;
    parity_errs = 0;
    cmd_cnt     = 0;
    min_gap     = 1 << 30;
    for (int i = 0; i < 2**ADDR_WIDTH; i++)
      regs[i] = 8'(i * 37 + 11);
    wait (rst_n === 1'b1);
    forever
    begin
      receive_frame(hi, idle);
      cmd_cnt++;
      if (hi[DATA_WIDTH-1])
      begin
        receive_frame(lo, idle);
        // Idle count starts at the middle of the stop bit.
        if (idle - CLKS_PER_BIT / 2 < min_gap)
          min_gap = idle - CLKS_PER_BIT / 2;
        regs[hi[ADDR_WIDTH-1:0]] = lo;
      end
      else if (!silent)
      begin
        repeat (RESP_DELAY) @(posedge clk);
        send_frame(regs[hi[ADDR_WIDTH-1:0]]);
      end
    end
  end

endmodule

// ==== sim/tb_uart_cmd_bridge.sv ====
`timescale 1ns/1ps

module tb_uart_cmd_bridge;
  import uart_bridge_pkg::*;

  localparam int NUM_RAND   = 8;
  localparam int NUM_CMDS   = 2 + 2 * NUM_RAND + 1 + 2;
  localparam int CMD_WORST  = 2 * CLKS_PER_BIT * FRAME_BITS + GAP_CYCLES + RESP_TIMEOUT;
  localparam int MAX_CYCLES = 2 * NUM_CMDS * CMD_WORST;

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  tx;
  logic                  rx;
  logic                  read_vld;
  logic [DATA_WIDTH-1:0] read_data;
  logic                  read_err;
  logic                  corrupt_parity;
  logic                  silent;
  int                    frame_errs;
  int                    parity_errs;
  int                    cmd_cnt;
  int                    min_gap;
  int                    cycle_cnt;
  int                    err_cnt;
  int                    accepted;
  int                    tests_run;
  int                    tests_failed;
  int                    err_base;
  logic [DATA_WIDTH-1:0] mirror [2**ADDR_WIDTH];
  logic [ADDR_WIDTH-1:0] addr_list [NUM_RAND];

  uart_cmd_bridge uart_cmd_bridge_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_device_model device_model_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .tx             (tx),
    .corrupt_parity (corrupt_parity),
    .silent         (silent),
    .rx             (rx),
    .frame_errs     (frame_errs),
    .parity_errs    (parity_errs),
    .cmd_cnt        (cmd_cnt),
    .min_gap        (min_gap)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Run stopped after %0d cycles, the bridge never finished.", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp)
    else
    begin
      $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == err_base)
      $display("Test %0d %s: ok", tests_run, name);
    else
    begin
      $display("Test %0d %s: %0d failed checks", tests_run, name, err_cnt - err_base);
      tests_failed++;
    end
    err_base = err_cnt;
  endtask

  // Called 1 ns after an edge. cmd_vld stays high afterwards.
  task automatic issue_cmd(input logic [CMD_WIDTH-1:0] word);
    cmd_in  = word;
    cmd_vld = 1'b1;
    do
      @(posedge clk);
    while (!cmd_rdy);
    #1;
    accepted++;
  endtask

  task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
    issue_cmd({1'b1, addr, data});
    mirror[addr] = data;
  endtask

  task automatic read_reg(input logic [ADDR_WIDTH-1:0] addr, output logic [DATA_WIDTH-1:0] data,
                          output logic err);
    issue_cmd({1'b0, addr, 8'h00});
    cmd_vld = 1'b0;
    do
      @(posedge clk);
    while (!read_vld);
    data = read_data;
    err  = read_err;
    #1;
  endtask

  initial
  begin
    logic [DATA_WIDTH-1:0] data;
    logic                  err;
    clk            = 1'b0;
    rst_n          = 1'b0;
    cmd_in         = '0;
    cmd_vld        = 1'b0;
    corrupt_parity = 1'b0;
    silent         = 1'b0;
    cycle_cnt      = 0;
    err_cnt        = 0;
    accepted       = 0;
    tests_run      = 0;
    tests_failed   = 0;
    err_base       = 0;
    void'($urandom(32'h8c67));
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    @(posedge clk);
    check_value("tx", int'(tx), 1);
    check_value("cmd_rdy", int'(cmd_rdy), 1);
    check_value("read_vld", int'(read_vld), 0);
    #1;
    end_test("reset state");

    write_reg(7'h2a, 8'hc3);
    read_reg(7'h2a, data, err);
    check_value("read_data", int'(data), int'(mirror[7'h2a]));
    check_value("read_err", int'(err), 0);
    end_test("write then read back");

    // Writes go back to back, so cmd_vld is held through each busy period.
    for (int i = 0; i < NUM_RAND; i++)
    begin
      addr_list[i] = 7'($urandom());
      write_reg(addr_list[i], 8'($urandom()));
    end
    for (int i = 0; i < NUM_RAND; i++)
    begin
      read_reg(addr_list[i], data, err);
      check_value("read_data", int'(data), int'(mirror[addr_list[i]]));
      check_value("read_err", int'(err), 0);
    end
    end_test("random writes and reads");

    check_value("parity_errs", parity_errs, 0);
    check_value("frame_errs", frame_errs, 0);
    check_value("cmd_cnt", cmd_cnt, accepted);
    assert (min_gap >= GAP_CYCLES)
    else
    begin
      $display("[ERROR] %0t min_gap: got %0d, expected at least %0d", $time, min_gap, GAP_CYCLES);
      err_cnt++;
    end
    end_test("frame format and gap");

    corrupt_parity = 1'b1;
    read_reg(7'h2a, data, err);
    check_value("read_err", int'(err), 1);
    corrupt_parity = 1'b0;
    end_test("corrupted parity");

    silent = 1'b1;
    read_reg(addr_list[0], data, err);
    check_value("read_data", int'(data), 0);
    check_value("read_err", int'(err), 1);
    @(posedge clk);
    check_value("cmd_rdy", int'(cmd_rdy), 1); // Back to idle one cycle after read_vld.
    #1 silent = 1'b0;
    read_reg(addr_list[0], data, err);
    check_value("read_data", int'(data), int'(mirror[addr_list[0]]));
    check_value("read_err", int'(err), 0);
    end_test("silent device");

    $display("Tests run %0d, failed %0d, failed checks %0d, commands %0d",
             tests_run, tests_failed, err_cnt, accepted);
    if (err_cnt == 0 && tests_failed == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
common/uart_bridge_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
verilog/cmd_sequencer.sv
verilog/uart_cmd_bridge.sv
sim/uart_device_model.sv
sim/tb_uart_cmd_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run the testbench and search the log for the pass line.
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f src.f --top-module tb_uart_cmd_bridge -o tb_sim &&
./obj_dir/tb_sim | tee sim.log
grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed, see sim.log"; exit 1; }
